// ==== vlog.f ====
decode_pkg.sv
imm_gen.sv
instr_decoder.sv
reg_file.sv
decode_top.sv
tb_clock_gen.sv
decode_assert.sv
decode_tb.sv

// ==== Makefile ====
# Verilator build and run for the decode stage testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f vlog.f --top-module decode_tb -o decode_sim
	@out="$$(./obj_dir/decode_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== decode_tb.sv ====
// Directed testbench for the decode stage with register file and decoder checks
`timescale 1ns/1ps

module decode_tb;

   logic                     clk;
   logic                     rst_n_i;
   decode_pkg::if2id_data_s  if_data;
   decode_pkg::if2id_ctrl_s  if_ctrl;
   decode_pkg::if2id_ctrl_s  ctrl_next;          // Fetch status for the next instruction
   decode_pkg::wrb2id_fb_s   wrb_fb;
   decode_pkg::wrb2id_fb_s   wrb_next;           // Applied with the next instruction
   decode_pkg::id2exe_data_s id_data;
   decode_pkg::id2exe_ctrl_s id_ctrl;
   int                       errors;
   string                    cur_test;
   logic [31:0]              model [32];

   tb_clock_gen #(.period(40ns)) clock_inst (.clk_o(clk));

   decode_top #(.num_regs(32)) decode_top_inst (
      .clk_i         (clk),
      .rst_n_i       (rst_n_i),
      .if2id_data_i  (if_data),
      .if2id_ctrl_i  (if_ctrl),
      .wrb2id_fb_i   (wrb_fb),
      .id2exe_data_o (id_data),
      .id2exe_ctrl_o (id_ctrl)
   );

   function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd, logic [4:0] opc);
      return {f7, rs2, rs1, f3, rd, opc, 2'b11};  // Also I, S and B with split fields
   endfunction

   function automatic decode_pkg::id2exe_ctrl_s ctrl_ok(
         decode_pkg::alu_ops_e alu, decode_pkg::ld_ops_e ld, decode_pkg::st_ops_e st,
         decode_pkg::br_ops_e br, decode_pkg::opr1_sel_e o1, decode_pkg::opr2_sel_e o2,
         decode_pkg::cmp_opr2_sel_e cmp, decode_pkg::rd_wrb_sel_e wrb,
         logic wr, logic jmp, logic brq);
      return '{alu_ops: alu, ld_ops: ld, st_ops: st, br_ops: br, opr1_sel: o1,
               opr2_sel: o2, cmp_opr2_sel: cmp, rd_wrb_sel: wrb,
               exc_code: decode_pkg::EXC_CODE_NO_EXCEPTION, rd_wr_req: wr,
               jump_req: jmp, branch_req: brq, exc_req: 1'b0};
   endfunction

   // Default fields plus an exception
   function automatic decode_pkg::id2exe_ctrl_s exc_ctrl(decode_pkg::exc_code_e code);
      decode_pkg::id2exe_ctrl_s c;
      c = ctrl_ok(decode_pkg::ALU_OPS_NONE, decode_pkg::LD_OPS_NONE, decode_pkg::ST_OPS_NONE,
                  decode_pkg::BR_OPS_NONE, decode_pkg::ALU_OPR1_PC, decode_pkg::ALU_OPR2_IMM,
                  decode_pkg::ALU_CMP_OPR2_REG, decode_pkg::RD_WRB_NONE, 1'b0, 1'b0, 1'b0);
      c.exc_req  = 1'b1;
      c.exc_code = code;
      return c;
   endfunction

   task automatic apply_instr(input logic [31:0] instr);
      logic [31:0] r;
      @(posedge clk);
      #2;
      r               = $urandom;
      if_data.pc      = {r[31:2], 2'b00};
      if_data.pc_next = {r[31:2], 2'b00} + 32'd4;
      if_data.instr   = instr;
      if_ctrl         = ctrl_next;
      wrb_fb          = wrb_next;
      #20;                                       // Sample well before the next edge
      check_val({cur_test, " instr"}, instr, id_data.instr);
      check_val({cur_test, " pc"}, if_data.pc, id_data.pc);
      check_val({cur_test, " pc_next"}, if_data.pc_next, id_data.pc_next);
   endtask

   task automatic check_ctrl(input string name, input decode_pkg::id2exe_ctrl_s exp);
      if (id_ctrl !== exp) begin
         $display("ERR %s instr %h ctrl expected %h actual %h", name, if_data.instr,
                  exp, id_ctrl);
         errors++;
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("ERR %s instr %h expected %h actual %h", name, if_data.instr, exp, act);
         errors++;
      end
   endtask

   task automatic test_reset_regs();
      cur_test = "test_reset_regs";
      for (int a = 0; a < 32; a++) begin
         for (int b = 0; b < 32; b++) begin
            apply_instr(enc_r(7'h00, 5'(b), 5'(a), 3'b000, 5'd1, decode_pkg::OPCODE_ARITH));
            check_val("test_reset_regs", 32'h0, id_data.rs1_data);
            check_val("test_reset_regs", 32'h0, id_data.rs2_data);
         end
      end
   endtask

   task automatic test_writeback();
      logic [31:0] val;
      cur_test = "test_writeback";
      for (int r = 0; r < 32; r++) begin
         val      = $urandom;
         wrb_next = '{rd_wr_req: 1'b1, rd_addr: 5'(r), rd_data: val};
         apply_instr(enc_r(7'h00, 5'(r), 5'(r), 3'b000, 5'd2, decode_pkg::OPCODE_ARITH));
         check_val("test_writeback old", model[r], id_data.rs1_data);  // No bypass
         if (r != 0) model[r] = val;
      end
      wrb_next = '0;
      for (int r = 0; r < 32; r++) begin
         apply_instr(enc_r(7'h00, 5'(31 - r), 5'(r), 3'b000, 5'd3, decode_pkg::OPCODE_ARITH));
         check_val("test_writeback rs1", model[r], id_data.rs1_data);
         check_val("test_writeback rs2", model[31 - r], id_data.rs2_data);
      end
   endtask

   task automatic test_alu_decode();
      decode_pkg::alu_ops_e ops [8];
      logic [31:0]          r;
      cur_test = "test_alu_decode";
      ops = '{decode_pkg::ALU_OPS_ADD, decode_pkg::ALU_OPS_SLL, decode_pkg::ALU_OPS_SLT,
              decode_pkg::ALU_OPS_SLTU, decode_pkg::ALU_OPS_XOR, decode_pkg::ALU_OPS_SRL,
              decode_pkg::ALU_OPS_OR, decode_pkg::ALU_OPS_AND};
      for (int f3 = 0; f3 < 8; f3++) begin
         r = $urandom;
         apply_instr(enc_r(7'h00, r[4:0], r[9:5], 3'(f3), r[14:10], decode_pkg::OPCODE_ARITH));
         check_ctrl("test_alu_decode arith", ctrl_ok(ops[f3], decode_pkg::LD_OPS_NONE,
            decode_pkg::ST_OPS_NONE, decode_pkg::BR_OPS_NONE, decode_pkg::ALU_OPR1_REG,
            decode_pkg::ALU_OPR2_REG, decode_pkg::ALU_CMP_OPR2_REG, decode_pkg::RD_WRB_ALU,
            1'b1, 1'b0, 1'b0));
         // Immediate forms where shifts carry a shamt
         if (f3 == 1 || f3 == 5) begin
            apply_instr(enc_r(7'h00, r[4:0], r[9:5], 3'(f3), r[14:10], decode_pkg::OPCODE_IMM));
            check_val("test_alu_decode shamt", {27'h0, r[4:0]}, id_data.imm);
         end else begin
            apply_instr(enc_r(r[31:25], r[4:0], r[9:5], 3'(f3), r[14:10],
                              decode_pkg::OPCODE_IMM));
            check_val("test_alu_decode imm", {{20{r[31]}}, r[31:25], r[4:0]}, id_data.imm);
         end
         check_ctrl("test_alu_decode imm", ctrl_ok(ops[f3], decode_pkg::LD_OPS_NONE,
            decode_pkg::ST_OPS_NONE, decode_pkg::BR_OPS_NONE, decode_pkg::ALU_OPR1_REG,
            decode_pkg::ALU_OPR2_IMM, decode_pkg::ALU_CMP_OPR2_IMM, decode_pkg::RD_WRB_ALU,
            1'b1, 1'b0, 1'b0));
      end
      // SUB and SRA in register and immediate forms
      for (int k = 0; k < 3; k++) begin
         r = $urandom;
         apply_instr(enc_r(7'h20, r[4:0], r[9:5], (k == 0) ? 3'b000 : 3'b101, r[14:10],
                           (k == 2) ? decode_pkg::OPCODE_IMM : decode_pkg::OPCODE_ARITH));
         check_ctrl("test_alu_decode alt", ctrl_ok((k == 0) ? decode_pkg::ALU_OPS_SUB :
            decode_pkg::ALU_OPS_SRA, decode_pkg::LD_OPS_NONE, decode_pkg::ST_OPS_NONE,
            decode_pkg::BR_OPS_NONE, decode_pkg::ALU_OPR1_REG,
            (k == 2) ? decode_pkg::ALU_OPR2_IMM : decode_pkg::ALU_OPR2_REG,
            (k == 2) ? decode_pkg::ALU_CMP_OPR2_IMM : decode_pkg::ALU_CMP_OPR2_REG,
            decode_pkg::RD_WRB_ALU, 1'b1, 1'b0, 1'b0));
      end
   endtask

   task automatic test_mem_flow_decode();
      decode_pkg::ld_ops_e ld [8];
      decode_pkg::br_ops_e br [8];
      logic [31:0]         r;
      logic [12:0]         bo;
      logic [20:0]         jo;
      cur_test = "test_mem_flow_decode";
      ld = '{decode_pkg::LD_OPS_LB, decode_pkg::LD_OPS_LH, decode_pkg::LD_OPS_LW,
             decode_pkg::LD_OPS_NONE, decode_pkg::LD_OPS_LBU, decode_pkg::LD_OPS_LHU,
             decode_pkg::LD_OPS_NONE, decode_pkg::LD_OPS_NONE};
      br = '{decode_pkg::BR_OPS_EQ, decode_pkg::BR_OPS_NE, decode_pkg::BR_OPS_NONE,
             decode_pkg::BR_OPS_NONE, decode_pkg::BR_OPS_LT, decode_pkg::BR_OPS_GE,
             decode_pkg::BR_OPS_LTU, decode_pkg::BR_OPS_GEU};
      for (int f3 = 0; f3 < 8; f3++) begin
         r = $urandom;
         if (ld[f3] != decode_pkg::LD_OPS_NONE) begin
            apply_instr(enc_r(r[31:25], r[24:20], r[19:15], 3'(f3), r[11:7],
                              decode_pkg::OPCODE_LOAD));
            check_ctrl("test_mem_flow_decode load", ctrl_ok(decode_pkg::ALU_OPS_ADD, ld[f3],
               decode_pkg::ST_OPS_NONE, decode_pkg::BR_OPS_NONE, decode_pkg::ALU_OPR1_REG,
               decode_pkg::ALU_OPR2_IMM, decode_pkg::ALU_CMP_OPR2_REG,
               decode_pkg::RD_WRB_DMEM, 1'b1, 1'b0, 1'b0));
            check_val("test_mem_flow_decode load imm", {{20{r[31]}}, r[31:20]}, id_data.imm);
         end
         if (f3 < 3) begin
            apply_instr(enc_r(r[31:25], r[24:20], r[19:15], 3'(f3), r[11:7],
                              decode_pkg::OPCODE_STORE));
            check_ctrl("test_mem_flow_decode store", ctrl_ok(decode_pkg::ALU_OPS_ADD,
               decode_pkg::LD_OPS_NONE, decode_pkg::st_ops_e'(f3 + 1), decode_pkg::BR_OPS_NONE,
               decode_pkg::ALU_OPR1_REG, decode_pkg::ALU_OPR2_IMM,
               decode_pkg::ALU_CMP_OPR2_REG, decode_pkg::RD_WRB_NONE, 1'b0, 1'b0, 1'b0));
            check_val("test_mem_flow_decode store imm", {{20{r[31]}}, r[31:25], r[11:7]},
                      id_data.imm);
         end
         if (br[f3] != decode_pkg::BR_OPS_NONE) begin
            bo = {r[12:1], 1'b0};
            apply_instr(enc_r({bo[12], bo[10:5]}, r[24:20], r[19:15], 3'(f3),
                              {bo[4:1], bo[11]}, decode_pkg::OPCODE_BRANCH));
            check_ctrl("test_mem_flow_decode branch", ctrl_ok(decode_pkg::ALU_OPS_ADD,
               decode_pkg::LD_OPS_NONE, decode_pkg::ST_OPS_NONE, br[f3],
               decode_pkg::ALU_OPR1_PC, decode_pkg::ALU_OPR2_IMM,
               decode_pkg::ALU_CMP_OPR2_REG, decode_pkg::RD_WRB_NONE, 1'b0, 1'b0, 1'b1));
            check_val("test_mem_flow_decode branch imm", {{19{bo[12]}}, bo}, id_data.imm);
         end
      end
      r  = $urandom;
      jo = {r[20:1], 1'b0};
      apply_instr({jo[20], jo[10:1], jo[11], jo[19:12], r[11:7], decode_pkg::OPCODE_JAL, 2'b11});
      check_ctrl("test_mem_flow_decode jal", ctrl_ok(decode_pkg::ALU_OPS_ADD,
         decode_pkg::LD_OPS_NONE, decode_pkg::ST_OPS_NONE, decode_pkg::BR_OPS_NONE,
         decode_pkg::ALU_OPR1_PC, decode_pkg::ALU_OPR2_IMM, decode_pkg::ALU_CMP_OPR2_REG,
         decode_pkg::RD_WRB_INC_PC, 1'b1, 1'b1, 1'b0));
      check_val("test_mem_flow_decode jal imm", {{11{jo[20]}}, jo}, id_data.imm);
      apply_instr(enc_r(r[31:25], r[24:20], r[19:15], 3'b000, r[11:7], decode_pkg::OPCODE_JALR));
      check_ctrl("test_mem_flow_decode jalr", ctrl_ok(decode_pkg::ALU_OPS_ADD,
         decode_pkg::LD_OPS_NONE, decode_pkg::ST_OPS_NONE, decode_pkg::BR_OPS_NONE,
         decode_pkg::ALU_OPR1_REG, decode_pkg::ALU_OPR2_IMM, decode_pkg::ALU_CMP_OPR2_REG,
         decode_pkg::RD_WRB_INC_PC, 1'b1, 1'b1, 1'b0));
      check_val("test_mem_flow_decode jalr imm", {{20{r[31]}}, r[31:20]}, id_data.imm);
      for (int k = 0; k < 2; k++) begin
         apply_instr({r[31:12], r[11:7], (k == 0) ? decode_pkg::OPCODE_LUI :
                      decode_pkg::OPCODE_AUIPC, 2'b11});
         check_ctrl("test_mem_flow_decode upper", ctrl_ok((k == 0) ?
            decode_pkg::ALU_OPS_COPY_OPR2 : decode_pkg::ALU_OPS_ADD, decode_pkg::LD_OPS_NONE,
            decode_pkg::ST_OPS_NONE, decode_pkg::BR_OPS_NONE, decode_pkg::ALU_OPR1_PC,
            decode_pkg::ALU_OPR2_IMM, decode_pkg::ALU_CMP_OPR2_REG, decode_pkg::RD_WRB_ALU,
            1'b1, 1'b0, 1'b0));
         check_val("test_mem_flow_decode upper imm", {r[31:12], 12'h0}, id_data.imm);
      end
   endtask

   task automatic test_illegal_and_fault();
      logic [31:0] bad [$];
      cur_test = "test_illegal_and_fault";
      bad = '{enc_r(7'h0, 5'd1, 5'd2, 3'd3, 5'd3, decode_pkg::OPCODE_LOAD),
              enc_r(7'h0, 5'd1, 5'd2, 3'd6, 5'd3, decode_pkg::OPCODE_LOAD),
              enc_r(7'h0, 5'd1, 5'd2, 3'd3, 5'd3, decode_pkg::OPCODE_STORE),
              enc_r(7'h0, 5'd1, 5'd2, 3'd5, 5'd3, decode_pkg::OPCODE_STORE),
              enc_r(7'h0, 5'd1, 5'd2, 3'd2, 5'd3, decode_pkg::OPCODE_BRANCH),
              enc_r(7'h0, 5'd1, 5'd2, 3'd3, 5'd3, decode_pkg::OPCODE_BRANCH),
              enc_r(7'h0, 5'd1, 5'd2, 3'd1, 5'd3, decode_pkg::OPCODE_JALR),
              enc_r(7'h01, 5'd1, 5'd2, 3'd0, 5'd3, decode_pkg::OPCODE_ARITH),  // MUL
              enc_r(7'h20, 5'd1, 5'd2, 3'd1, 5'd3, decode_pkg::OPCODE_ARITH),
              enc_r(7'h20, 5'd1, 5'd2, 3'd1, 5'd3, decode_pkg::OPCODE_IMM),
              enc_r(7'h10, 5'd1, 5'd2, 3'd5, 5'd3, decode_pkg::OPCODE_IMM),
              enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd3, 5'b01011),                   // AMO
              enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 5'b11100),                   // ECALL
              enc_r(7'h00, 5'd0, 5'd0, 3'd1, 5'd3, 5'b11100),                   // CSR
              enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 5'b00011),                   // FENCE
              32'h0000_0000};
      foreach (bad[i]) begin
         apply_instr(bad[i]);
         check_ctrl("test_illegal_and_fault illegal",
                    exc_ctrl(decode_pkg::EXC_CODE_ILLEGAL_INSTR));
      end
      ctrl_next = '{exc_req: 1'b1, exc_code: decode_pkg::EXC_CODE_INSTR_ACC_FAULT};
      bad.push_back(enc_r(7'h0, 5'd4, 5'd5, 3'd0, 5'd6, decode_pkg::OPCODE_ARITH));
      bad.push_back(enc_r(7'h0, 5'd4, 5'd5, 3'd0, 5'd6, decode_pkg::OPCODE_JAL));
      foreach (bad[i]) begin
         apply_instr(bad[i]);
         check_ctrl("test_illegal_and_fault fault",
                    exc_ctrl(decode_pkg::EXC_CODE_INSTR_ACC_FAULT));
      end
      ctrl_next = '{exc_req: 1'b0, exc_code: decode_pkg::EXC_CODE_NO_EXCEPTION};
   endtask

   initial begin
      rst_n_i = 1'b0;
      repeat (16) @(posedge clk);
      #2 rst_n_i = 1'b1;                         // Release 16 cycles after start
   end

   initial begin
      int wait_cnt;
      void'($urandom(32'h25719215));
      errors    = 0;
      cur_test  = "reset";
      if_data   = '0;
      if_ctrl   = '{exc_req: 1'b0, exc_code: decode_pkg::EXC_CODE_NO_EXCEPTION};
      ctrl_next = '{exc_req: 1'b0, exc_code: decode_pkg::EXC_CODE_NO_EXCEPTION};
      wrb_fb    = '0;
      wrb_next  = '0;
      foreach (model[i]) model[i] = 32'h0;
      wait_cnt = 0;
      while (rst_n_i !== 1'b1 && wait_cnt < 100) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (rst_n_i !== 1'b1) begin
         $display("Reset was not released in time");
         $display("Test failed");
         $finish;
      end else begin
         test_reset_regs();
         test_writeback();
         test_alu_decode();
         test_mem_flow_decode();
         test_illegal_and_fault();
         $display("Checks finished with %0d errors", errors);
         if (errors == 0) begin
            $display("Test completed successfully");
         end else begin
            $display("Test failed");
         end
         $finish;
      end
   end

endmodule : decode_tb

// ==== decode_assert.sv ====
// Concurrent assertions on the decode stage control outputs
`timescale 1ns/1ps

module decode_assert (
   input logic                     clk_i,
   input logic                     rst_n_i,
   input decode_pkg::id2exe_ctrl_s ctrl_i
);

   // An exception cancels writeback and control flow
   exc_excludes_req : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      ctrl_i.exc_req |-> !(ctrl_i.rd_wr_req || ctrl_i.jump_req || ctrl_i.branch_req)
   ) else $error("exception with a request flag set");

   jump_branch_excl : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !(ctrl_i.jump_req && ctrl_i.branch_req)
   ) else $error("jump and branch requested together");

   // Cause code only present with an exception
   code_matches_req : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (ctrl_i.exc_code == decode_pkg::EXC_CODE_NO_EXCEPTION) == !ctrl_i.exc_req
   ) else $error("exception code does not match exception request");

endmodule : decode_assert

bind decode_top decode_assert decode_assert_inst (
   .clk_i   (clk_i),
   .rst_n_i (rst_n_i),
   .ctrl_i  (id2exe_ctrl_o)
);

// ==== tb_clock_gen.sv ====
// Testbench clock source
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter realtime period = 40ns
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(period / 2) clk_o = ~clk_o;            // Free running
      end
   end

endmodule : tb_clock_gen

// ==== decode_top.sv ====
// Decode stage top level with decoder, immediate generator and register file
`timescale 1ns/1ps

module decode_top #(
   parameter int num_regs = 32
) (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  decode_pkg::if2id_data_s   if2id_data_i,
   input  decode_pkg::if2id_ctrl_s   if2id_ctrl_i,
   input  decode_pkg::wrb2id_fb_s    wrb2id_fb_i,
   output decode_pkg::id2exe_data_s  id2exe_data_o,
   output decode_pkg::id2exe_ctrl_s  id2exe_ctrl_o
);

   logic [decode_pkg::xlen-1:0] instr;
   logic [decode_pkg::xlen-1:0] imm;
   logic [decode_pkg::xlen-1:0] rs1_data;
   logic [decode_pkg::xlen-1:0] rs2_data;
   decode_pkg::imm_sel_e        imm_sel;

   assign instr = if2id_data_i.instr;

   instr_decoder instr_decoder_inst (
      .instr_i      (instr),
      .fetch_ctrl_i (if2id_ctrl_i),
      .ctrl_o       (id2exe_ctrl_o),
      .imm_sel_o    (imm_sel)
   );

   imm_gen imm_gen_inst (
      .instr_i   (instr),
      .imm_sel_i (imm_sel),
      .imm_o     (imm)
   );

   reg_file #(
      .num_regs (num_regs)
   ) reg_file_inst (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rs1_addr_i (instr[19:15]),                // rs1 field
      .rs2_addr_i (instr[24:20]),                // rs2 field
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .wrb_fb_i   (wrb2id_fb_i)
   );

   assign id2exe_data_o = '{
      imm      : imm,
      rs1_data : rs1_data,
      rs2_data : rs2_data,
      instr    : instr,
      pc       : if2id_data_i.pc,
      pc_next  : if2id_data_i.pc_next
   };

endmodule : decode_top

// ==== reg_file.sv ====
// Integer register file with two combinational reads and one synchronous write
`timescale 1ns/1ps

module reg_file #(
   parameter int num_regs = 32
) (
   input  logic                             clk_i,
   input  logic                             rst_n_i,
   input  logic [decode_pkg::rf_awidth-1:0] rs1_addr_i,
   input  logic [decode_pkg::rf_awidth-1:0] rs2_addr_i,
   output logic [decode_pkg::xlen-1:0]      rs1_data_o,
   output logic [decode_pkg::xlen-1:0]      rs2_data_o,
   input  decode_pkg::wrb2id_fb_s           wrb_fb_i
);

   localparam int idx_w = $clog2(num_regs);      // Array index width

   logic [decode_pkg::xlen-1:0] regs [num_regs];
   logic                        wr_en;

   // x0 and addresses past the array never take a write
   assign wr_en = wrb_fb_i.rd_wr_req && (wrb_fb_i.rd_addr != '0) &&
                  (int'(wrb_fb_i.rd_addr) < num_regs);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wrb_fb_i.rd_addr[idx_w-1:0]] <= wrb_fb_i.rd_data;
      end
   end

   // No bypass, a write shows up one cycle later
   always_comb begin
      rs1_data_o = '0;
      rs2_data_o = '0;
      if ((rs1_addr_i != '0) && (int'(rs1_addr_i) < num_regs)) begin
         rs1_data_o = regs[rs1_addr_i[idx_w-1:0]];
      end
      if ((rs2_addr_i != '0) && (int'(rs2_addr_i) < num_regs)) begin
         rs2_data_o = regs[rs2_addr_i[idx_w-1:0]];
      end
   end

endmodule : reg_file

// ==== instr_decoder.sv ====
// RV32I instruction decoder producing execute controls and the immediate format
`timescale 1ns/1ps

module instr_decoder (
   input  logic [decode_pkg::xlen-1:0] instr_i,
   input  decode_pkg::if2id_ctrl_s     fetch_ctrl_i,
   output decode_pkg::id2exe_ctrl_s    ctrl_o,
   output decode_pkg::imm_sel_e        imm_sel_o
);

   // Control word of an instruction that does nothing
   localparam decode_pkg::id2exe_ctrl_s ctrl_default = '{
      alu_ops      : decode_pkg::ALU_OPS_NONE,
      ld_ops       : decode_pkg::LD_OPS_NONE,
      st_ops       : decode_pkg::ST_OPS_NONE,
      br_ops       : decode_pkg::BR_OPS_NONE,
      opr1_sel     : decode_pkg::ALU_OPR1_PC,
      opr2_sel     : decode_pkg::ALU_OPR2_IMM,
      cmp_opr2_sel : decode_pkg::ALU_CMP_OPR2_REG,
      rd_wrb_sel   : decode_pkg::RD_WRB_NONE,
      exc_code     : decode_pkg::EXC_CODE_NO_EXCEPTION,
      rd_wr_req    : 1'b0,
      jump_req     : 1'b0,
      branch_req   : 1'b0,
      exc_req      : 1'b0
   };

   decode_pkg::rv_opcode_e opcode;
   logic [2:0]             funct3;
   logic [6:0]             funct7;
   logic                   illegal_instr;

   assign opcode = decode_pkg::rv_opcode_e'(instr_i[6:2]);
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   always_comb begin
      ctrl_o        = ctrl_default;
      imm_sel_o     = decode_pkg::IMM_SEL_I;
      illegal_instr = 1'b0;

      if (fetch_ctrl_i.exc_req) begin                        // Fetch fault wins over decode
         ctrl_o.exc_req  = 1'b1;
         ctrl_o.exc_code = fetch_ctrl_i.exc_code;
      end else if (instr_i[1:0] != 2'b11) begin
         illegal_instr = 1'b1;                               // Not a 32-bit encoding
      end else begin
         case (opcode)
            decode_pkg::OPCODE_ARITH : begin
               ctrl_o.opr1_sel   = decode_pkg::ALU_OPR1_REG;
               ctrl_o.opr2_sel   = decode_pkg::ALU_OPR2_REG;
               ctrl_o.rd_wrb_sel = decode_pkg::RD_WRB_ALU;
               ctrl_o.rd_wr_req  = 1'b1;
               case (funct7)
                  7'b0000000 : begin
                     case (funct3)
                        3'b000  : ctrl_o.alu_ops = decode_pkg::ALU_OPS_ADD;
                        3'b001  : ctrl_o.alu_ops = decode_pkg::ALU_OPS_SLL;
                        3'b010  : ctrl_o.alu_ops = decode_pkg::ALU_OPS_SLT;
                        3'b011  : ctrl_o.alu_ops = decode_pkg::ALU_OPS_SLTU;
                        3'b100  : ctrl_o.alu_ops = decode_pkg::ALU_OPS_XOR;
                        3'b101  : ctrl_o.alu_ops = decode_pkg::ALU_OPS_SRL;
                        3'b110  : ctrl_o.alu_ops = decode_pkg::ALU_OPS_OR;
                        default : ctrl_o.alu_ops = decode_pkg::ALU_OPS_AND;
                     endcase
                  end
                  7'b0100000 : begin
                     case (funct3)
                        3'b000  : ctrl_o.alu_ops = decode_pkg::ALU_OPS_SUB;
                        3'b101  : ctrl_o.alu_ops = decode_pkg::ALU_OPS_SRA;
                        default : illegal_instr  = 1'b1;
                     endcase
                  end
                  default : illegal_instr = 1'b1;            // M extension and others
               endcase
            end

            decode_pkg::OPCODE_IMM : begin
               ctrl_o.opr1_sel     = decode_pkg::ALU_OPR1_REG;
               ctrl_o.cmp_opr2_sel = decode_pkg::ALU_CMP_OPR2_IMM;
               ctrl_o.rd_wrb_sel   = decode_pkg::RD_WRB_ALU;
               ctrl_o.rd_wr_req    = 1'b1;
               case (funct3)
                  3'b000 : ctrl_o.alu_ops = decode_pkg::ALU_OPS_ADD;
                  3'b010 : ctrl_o.alu_ops = decode_pkg::ALU_OPS_SLT;
                  3'b011 : ctrl_o.alu_ops = decode_pkg::ALU_OPS_SLTU;
                  3'b100 : ctrl_o.alu_ops = decode_pkg::ALU_OPS_XOR;
                  3'b110 : ctrl_o.alu_ops = decode_pkg::ALU_OPS_OR;
                  3'b111 : ctrl_o.alu_ops = decode_pkg::ALU_OPS_AND;
                  3'b001 : begin
                     imm_sel_o = decode_pkg::IMM_SEL_SHAMT;
                     if (funct7 == 7'b0000000) ctrl_o.alu_ops = decode_pkg::ALU_OPS_SLL;
                     else                      illegal_instr  = 1'b1;
                  end
                  default : begin                            // Right shifts
                     imm_sel_o = decode_pkg::IMM_SEL_SHAMT;
                     case (funct7)
                        7'b0000000 : ctrl_o.alu_ops = decode_pkg::ALU_OPS_SRL;
                        7'b0100000 : ctrl_o.alu_ops = decode_pkg::ALU_OPS_SRA;
                        default    : illegal_instr  = 1'b1;
                     endcase
                  end
               endcase
            end

            decode_pkg::OPCODE_AUIPC : begin
               ctrl_o.alu_ops    = decode_pkg::ALU_OPS_ADD;   // pc plus upper immediate
               ctrl_o.rd_wrb_sel = decode_pkg::RD_WRB_ALU;
               ctrl_o.rd_wr_req  = 1'b1;
               imm_sel_o         = decode_pkg::IMM_SEL_U;
            end

            decode_pkg::OPCODE_LUI : begin
               ctrl_o.alu_ops    = decode_pkg::ALU_OPS_COPY_OPR2;
               ctrl_o.rd_wrb_sel = decode_pkg::RD_WRB_ALU;
               ctrl_o.rd_wr_req  = 1'b1;
               imm_sel_o         = decode_pkg::IMM_SEL_U;
            end

            decode_pkg::OPCODE_LOAD : begin
               ctrl_o.opr1_sel   = decode_pkg::ALU_OPR1_REG;
               ctrl_o.alu_ops    = decode_pkg::ALU_OPS_ADD;   // Address calculation
               ctrl_o.rd_wrb_sel = decode_pkg::RD_WRB_DMEM;
               ctrl_o.rd_wr_req  = 1'b1;
               case (funct3)
                  3'b000  : ctrl_o.ld_ops = decode_pkg::LD_OPS_LB;
                  3'b001  : ctrl_o.ld_ops = decode_pkg::LD_OPS_LH;
                  3'b010  : ctrl_o.ld_ops = decode_pkg::LD_OPS_LW;
                  3'b100  : ctrl_o.ld_ops = decode_pkg::LD_OPS_LBU;
                  3'b101  : ctrl_o.ld_ops = decode_pkg::LD_OPS_LHU;
                  default : illegal_instr = 1'b1;
               endcase
            end

            decode_pkg::OPCODE_STORE : begin
               ctrl_o.opr1_sel = decode_pkg::ALU_OPR1_REG;
               ctrl_o.alu_ops  = decode_pkg::ALU_OPS_ADD;
               imm_sel_o       = decode_pkg::IMM_SEL_S;
               case (funct3)
                  3'b000  : ctrl_o.st_ops = decode_pkg::ST_OPS_SB;
                  3'b001  : ctrl_o.st_ops = decode_pkg::ST_OPS_SH;
                  3'b010  : ctrl_o.st_ops = decode_pkg::ST_OPS_SW;
                  default : illegal_instr = 1'b1;
               endcase
            end

            decode_pkg::OPCODE_BRANCH : begin
               ctrl_o.alu_ops    = decode_pkg::ALU_OPS_ADD;   // Branch target from pc
               ctrl_o.branch_req = 1'b1;
               imm_sel_o         = decode_pkg::IMM_SEL_B;
               case (funct3)
                  3'b000  : ctrl_o.br_ops = decode_pkg::BR_OPS_EQ;
                  3'b001  : ctrl_o.br_ops = decode_pkg::BR_OPS_NE;
                  3'b100  : ctrl_o.br_ops = decode_pkg::BR_OPS_LT;
                  3'b101  : ctrl_o.br_ops = decode_pkg::BR_OPS_GE;
                  3'b110  : ctrl_o.br_ops = decode_pkg::BR_OPS_LTU;
                  3'b111  : ctrl_o.br_ops = decode_pkg::BR_OPS_GEU;
                  default : illegal_instr = 1'b1;
               endcase
            end

            decode_pkg::OPCODE_JALR : begin
               ctrl_o.opr1_sel   = decode_pkg::ALU_OPR1_REG;
               ctrl_o.alu_ops    = decode_pkg::ALU_OPS_ADD;
               ctrl_o.rd_wrb_sel = decode_pkg::RD_WRB_INC_PC;
               ctrl_o.rd_wr_req  = 1'b1;
               ctrl_o.jump_req   = 1'b1;
               if (funct3 != 3'b000) illegal_instr = 1'b1;
            end

            decode_pkg::OPCODE_JAL : begin
               ctrl_o.alu_ops    = decode_pkg::ALU_OPS_ADD;
               ctrl_o.rd_wrb_sel = decode_pkg::RD_WRB_INC_PC;
               ctrl_o.rd_wr_req  = 1'b1;
               ctrl_o.jump_req   = 1'b1;
               imm_sel_o         = decode_pkg::IMM_SEL_J;
            end

            default : illegal_instr = 1'b1;                  // SYSTEM, FENCE, AMO and unknown
         endcase
      end

      // An illegal instruction cancels everything it decoded
      if (illegal_instr) begin
         ctrl_o          = ctrl_default;
         ctrl_o.exc_req  = 1'b1;
         ctrl_o.exc_code = decode_pkg::EXC_CODE_ILLEGAL_INSTR;
      end
   end

endmodule : instr_decoder

// ==== imm_gen.sv ====
// Immediate generator for the I, shift, S, B, U and J formats
`timescale 1ns/1ps

module imm_gen (
   input  logic [decode_pkg::xlen-1:0] instr_i,
   input  decode_pkg::imm_sel_e        imm_sel_i,
   output logic [decode_pkg::xlen-1:0] imm_o
);

   logic sign;

   assign sign = instr_i[31];                     // Sign bit of every format

   always_comb begin
      case (imm_sel_i)
         decode_pkg::IMM_SEL_SHAMT : begin
            imm_o = {{(decode_pkg::xlen-5){1'b0}}, instr_i[24:20]};  // Zero-extended
         end
         decode_pkg::IMM_SEL_S : begin
            imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
         end
         decode_pkg::IMM_SEL_B : begin
            imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};       // Halfword aligned
         end
         decode_pkg::IMM_SEL_U : begin
            imm_o = {instr_i[31:12], 12'b0};
         end
         decode_pkg::IMM_SEL_J : begin
            imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
         end
         default : begin
            imm_o = {{20{sign}}, instr_i[31:20]};  // I format, also JALR
         end
      endcase
   end

endmodule : imm_gen

// ==== decode_pkg.sv ====
// Decode stage widths, opcode and control enums, and pipeline structs
package decode_pkg;

   localparam int unsigned xlen      = 32;       // Data and pc width
   localparam int unsigned rf_awidth = 5;        // Register address width

   // Major opcodes, bits 6..2 of the instruction
   typedef enum logic [4:0] {
      OPCODE_LOAD   = 5'b00000,
      OPCODE_IMM    = 5'b00100,
      OPCODE_AUIPC  = 5'b00101,
      OPCODE_STORE  = 5'b01000,
      OPCODE_ARITH  = 5'b01100,
      OPCODE_LUI    = 5'b01101,
      OPCODE_BRANCH = 5'b11000,
      OPCODE_JALR   = 5'b11001,
      OPCODE_JAL    = 5'b11011
   } rv_opcode_e;

   typedef enum logic [3:0] {
      ALU_OPS_NONE,
      ALU_OPS_ADD,
      ALU_OPS_SUB,
      ALU_OPS_SLL,
      ALU_OPS_SLT,
      ALU_OPS_SLTU,
      ALU_OPS_XOR,
      ALU_OPS_SRL,
      ALU_OPS_SRA,
      ALU_OPS_OR,
      ALU_OPS_AND,
      ALU_OPS_COPY_OPR2                           // LUI passes the immediate
   } alu_ops_e;

   typedef enum logic [2:0] {
      LD_OPS_NONE,
      LD_OPS_LB,
      LD_OPS_LH,
      LD_OPS_LW,
      LD_OPS_LBU,
      LD_OPS_LHU
   } ld_ops_e;

   typedef enum logic [1:0] {
      ST_OPS_NONE,
      ST_OPS_SB,
      ST_OPS_SH,
      ST_OPS_SW
   } st_ops_e;

   typedef enum logic [2:0] {
      BR_OPS_NONE,
      BR_OPS_EQ,
      BR_OPS_NE,
      BR_OPS_LT,
      BR_OPS_GE,
      BR_OPS_LTU,
      BR_OPS_GEU
   } br_ops_e;

   typedef enum logic {ALU_OPR1_PC, ALU_OPR1_REG} opr1_sel_e;
   typedef enum logic {ALU_OPR2_IMM, ALU_OPR2_REG} opr2_sel_e;
   typedef enum logic {ALU_CMP_OPR2_REG, ALU_CMP_OPR2_IMM} cmp_opr2_sel_e;

   typedef enum logic [1:0] {
      RD_WRB_NONE,
      RD_WRB_ALU,
      RD_WRB_DMEM,
      RD_WRB_INC_PC                               // Link address for jumps
   } rd_wrb_sel_e;

   // Standard RISC-V cause codes
   typedef enum logic [3:0] {
      EXC_CODE_INSTR_MISALIGN  = 4'd0,
      EXC_CODE_INSTR_ACC_FAULT = 4'd1,
      EXC_CODE_ILLEGAL_INSTR   = 4'd2,
      EXC_CODE_NO_EXCEPTION    = 4'd15
   } exc_code_e;

   typedef enum logic [2:0] {
      IMM_SEL_I,
      IMM_SEL_SHAMT,
      IMM_SEL_S,
      IMM_SEL_B,
      IMM_SEL_U,
      IMM_SEL_J
   } imm_sel_e;

   typedef struct packed {
      logic [xlen-1:0] pc;
      logic [xlen-1:0] pc_next;
      logic [xlen-1:0] instr;
   } if2id_data_s;

   typedef struct packed {
      logic            exc_req;                   // Fetch access fault
      exc_code_e       exc_code;
   } if2id_ctrl_s;

   typedef struct packed {
      logic [xlen-1:0] imm;
      logic [xlen-1:0] rs1_data;
      logic [xlen-1:0] rs2_data;
      logic [xlen-1:0] instr;
      logic [xlen-1:0] pc;
      logic [xlen-1:0] pc_next;
   } id2exe_data_s;

   typedef struct packed {
      alu_ops_e        alu_ops;
      ld_ops_e         ld_ops;
      st_ops_e         st_ops;
      br_ops_e         br_ops;
      opr1_sel_e       opr1_sel;
      opr2_sel_e       opr2_sel;
      cmp_opr2_sel_e   cmp_opr2_sel;
      rd_wrb_sel_e     rd_wrb_sel;
      exc_code_e       exc_code;
      logic            rd_wr_req;
      logic            jump_req;
      logic            branch_req;
      logic            exc_req;
   } id2exe_ctrl_s;

   typedef struct packed {
      logic                 rd_wr_req;
      logic [rf_awidth-1:0] rd_addr;
      logic [xlen-1:0]      rd_data;
   } wrb2id_fb_s;

endpackage : decode_pkg
